// File: Bender.yml
package:
  name: gmii_rx

sources:
  - include_dirs:
      - .
    files:
      - gmii_rx_pkg.sv
      - gmii_rx_phy_if.sv
      - gmii_rx_framer.sv
      - gmii_rx_crc_check.sv
      - gmii_rx_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_gmii_rx.sv

// File: gmii_rx_crc_check.sv
// ethernet fcs checker
`timescale 1ns/1ns
`default_nettype none

`include "gmii_rx_defs.svh"

module gmii_rx_crc_check import gmii_rx_pkg::*; (
    input  wire logic     clk_io,
    input  wire logic     reset,
    input  wire logic     out_valid,
    input  wire rx_byte_t out_byte,
    output logic          status_valid,
    output frame_status_t status
);

    crc32_t crc_q;
    crc32_t crc_next;
    logic   residue_ok;

    // one byte through the reflected crc, lsb first
    function automatic crc32_t crc_byte(input crc32_t crc_in, input gmii_byte_t data);
        crc32_t c;
        int     i;
        c = crc_in ^ {{(32 - `GMII_DATA_W){1'b0}}, data};
        for (i = 0; i < `GMII_DATA_W; i++) begin
            c = c[0] ? ((c >> 1) ^ `CRC32_POLY) : (c >> 1);
        end
        return c;
    endfunction

    assign crc_next   = crc_byte(crc_q, out_byte.data);
    // fcs bytes run through the same register, so a good frame lands on the residue
    assign residue_ok = (crc_next == `CRC32_RESIDUE);

    // running crc, preset to all ones at each frame start
    always_ff @(posedge clk_io) begin
        if (reset) begin
            crc_q        <= '1;
            status_valid <= 1'b0;
        end else begin
            status_valid <= 1'b0;
            if (out_valid) begin
                if (out_byte.last) begin
                    crc_q        <= '1;
                    status_valid <= 1'b1;
                end else begin
                    crc_q <= crc_next;
                end
            end
        end
    end

    // status word, only meaningful with status_valid
    always_ff @(posedge clk_io) begin
        if (out_valid && out_byte.last) begin
            status.bad_crc <= !residue_ok;
            // err is sticky, so the last byte carries the whole frame
            status.phy_err <= out_byte.err;
            status.good    <= residue_ok && !out_byte.err;
        end
    end

    // one status per frame, one cycle behind its last byte
    a_status_after_last: assert property (@(posedge clk_io) disable iff (reset)
        status_valid |-> $past(out_valid && out_byte.last))
        else $error("status_valid without a preceding last byte");

endmodule

`default_nettype wire

// File: gmii_rx_defs.svh
// gmii receive constants
`ifndef GMII_RX_DEFS_SVH
`define GMII_RX_DEFS_SVH

// width of one gmii data byte
`define GMII_DATA_W 8

// preamble filler and start-of-frame delimiter
`define GMII_PREAMBLE 8'h55
`define GMII_SFD 8'hD5

// fewest preamble bytes accepted ahead of the sfd
`define GMII_MIN_PREAMBLE 2

// reflected ieee 802.3 polynomial, lsb-first shift register
`define CRC32_POLY 32'hEDB88320

// register contents after data plus fcs on a good frame
// (no final inversion applied)
`define CRC32_RESIDUE 32'hDEBB20E3

`endif

// File: gmii_rx_framer.sv
// gmii preamble strip and byte framer
`timescale 1ns/1ns
`default_nettype none

`include "gmii_rx_defs.svh"

module gmii_rx_framer import gmii_rx_pkg::*; (
    input  wire logic      clk_io,
    input  wire logic      reset,
    input  wire gmii_sym_t sym,
    output logic           out_valid,
    output rx_byte_t       out_byte
);

    // preamble counter saturates at the minimum
    localparam int CNT_W = $clog2(`GMII_MIN_PREAMBLE + 1);
    localparam logic [CNT_W-1:0] CNT_MIN = CNT_W'(`GMII_MIN_PREAMBLE);

    framer_state_e    state;
    logic [CNT_W-1:0] pre_cnt;

    // one byte of lookahead so last is known when rx_dv drops
    gmii_byte_t hold_data;
    logic       hold_valid;
    logic       hold_err;
    logic       err_sticky;

    logic sym_is_data;
    logic sym_err;
    logic sym_pre;
    logic sym_sfd;

    // symbol classes
    assign sym_is_data = (sym.code == CODE_DATA) || (sym.code == CODE_DATA_ERR);
    assign sym_err     = (sym.code == CODE_DATA_ERR);
    assign sym_pre     = (sym.code == CODE_DATA) && (sym.data == `GMII_PREAMBLE);
    assign sym_sfd     = (sym.code == CODE_DATA) && (sym.data == `GMII_SFD);

    // fsm and control flags
    always_ff @(posedge clk_io) begin
        if (reset) begin
            state      <= ST_IDLE;
            pre_cnt    <= '0;
            hold_valid <= 1'b0;
            err_sticky <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (sym_pre) begin
                        state   <= ST_PREAMBLE;
                        pre_cnt <= CNT_W'(1);
                    end else if (sym_is_data) begin
                        // frame started mid-stream, skip it
                        state <= ST_DROP;
                    end
                end
                ST_PREAMBLE: begin
                    if (sym_pre) begin
                        if (pre_cnt != CNT_MIN) begin
                            pre_cnt <= pre_cnt + 1'b1;
                        end
                    end else if (sym_sfd && (pre_cnt >= CNT_MIN)) begin
                        state      <= ST_DATA;
                        hold_valid <= 1'b0;
                        err_sticky <= 1'b0;
                    end else if (!sym_is_data) begin
                        // carrier gone before sfd
                        state <= ST_IDLE;
                    end else begin
                        // short preamble, bad byte or error symbol
                        state <= ST_DROP;
                    end
                end
                ST_DATA: begin
                    // release the held byte on every new symbol
                    out_valid <= hold_valid;
                    if (sym_is_data) begin
                        hold_valid <= 1'b1;
                        err_sticky <= err_sticky | sym_err;
                    end else begin
                        hold_valid <= 1'b0;
                        state      <= ST_IDLE;
                    end
                end
                ST_DROP: begin
                    if (!sym_is_data) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // byte path
    always_ff @(posedge clk_io) begin
        if ((state == ST_DATA) && sym_is_data) begin
            hold_data <= sym.data;
            // err covers this byte and everything after it
            hold_err  <= err_sticky | sym_err;
        end
        if ((state == ST_DATA) && hold_valid) begin
            out_byte.data <= hold_data;
            out_byte.err  <= hold_err;
            // no further data symbol means the held byte closes the frame
            out_byte.last <= !sym_is_data;
        end
    end

    // a frame end is always followed by at least one quiet cycle
    a_gap_after_last: assert property (@(posedge clk_io) disable iff (reset)
        out_valid && out_byte.last |=> !out_valid)
        else $error("out_valid right after last byte");

endmodule

`default_nettype wire

// File: gmii_rx_phy_if.sv
// gmii receive capture and decode
`timescale 1ns/1ns
`default_nettype none

`include "gmii_rx_defs.svh"

module gmii_rx_phy_if import gmii_rx_pkg::*; (
    input  wire logic       clk_io,
    input  wire logic       reset,
    input  wire gmii_byte_t rxd,
    input  wire logic       rx_dv,
    input  wire logic       rx_er,
    output wire logic       rx_clk,
    output gmii_sym_t       sym,
    output logic            false_carrier
);

    // carrier indication byte sent with rx_er while rx_dv is low
    localparam gmii_byte_t FC_BYTE = `GMII_DATA_W'(8'h0E);

    (* IOB = "TRUE" *) gmii_byte_t rxd_q;
    (* IOB = "TRUE" *) logic rx_dv_q;
    (* IOB = "TRUE" *) logic rx_er_q;

    gmii_code_e code;
    gmii_code_e prev_code;

    // generic path, receive clock goes straight through to the logic
    assign rx_clk = clk_io;

    // data pins captured without reset
    always_ff @(posedge clk_io) begin
        rxd_q <= rxd;
    end

    // control pins and previous code
    always_ff @(posedge clk_io) begin
        if (reset) begin
            rx_dv_q   <= 1'b0;
            rx_er_q   <= 1'b0;
            prev_code <= CODE_IDLE;
        end else begin
            rx_dv_q   <= rx_dv;
            rx_er_q   <= rx_er;
            prev_code <= code;
        end
    end

    // pair decode per 802.3 table
    always_comb begin
        unique case ({rx_dv_q, rx_er_q})
            2'b00:   code = CODE_IDLE;
            2'b10:   code = CODE_DATA;
            2'b11:   code = CODE_DATA_ERR;
            default: code = (rxd_q == FC_BYTE) ? CODE_FALSE_CARRIER : CODE_RSVD;
        endcase
    end

    assign sym.code = code;
    assign sym.data = rxd_q;

    // one pulse when the false carrier starts out of idle
    assign false_carrier = (code == CODE_FALSE_CARRIER) && (prev_code == CODE_IDLE);

    // a false carrier event never coincides with a captured data byte
    a_fc_not_data: assert property (@(posedge clk_io) disable iff (reset)
        false_carrier |-> !rx_dv_q && !(sym.code inside {CODE_DATA, CODE_DATA_ERR}))
        else $error("false_carrier during data symbol");

endmodule

`default_nettype wire

// File: gmii_rx_pkg.sv
// gmii receive types
`default_nettype none

`include "gmii_rx_defs.svh"

package gmii_rx_pkg;

    // one data byte on the gmii bus
    typedef logic [`GMII_DATA_W-1:0] gmii_byte_t;

    // crc-32 shift register state
    typedef logic [31:0] crc32_t;

    // decoded rx_dv / rx_er pair
    typedef enum logic [2:0] {
        CODE_IDLE,
        CODE_DATA,
        CODE_DATA_ERR,
        CODE_FALSE_CARRIER,
        CODE_RSVD
    } gmii_code_e;

    // registered symbol out of the capture block
    typedef struct packed {
        gmii_code_e code;
        gmii_byte_t data;
    } gmii_sym_t;

    // framer fsm
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_DATA,
        ST_DROP
    } framer_state_e;

    // frame byte with end marker and sticky error
    typedef struct packed {
        gmii_byte_t data;
        logic       last;
        logic       err;
    } rx_byte_t;

    // one status word per frame
    typedef struct packed {
        logic good;
        logic bad_crc;
        logic phy_err;
    } frame_status_t;

endpackage

`default_nettype wire

// File: gmii_rx_top.sv
// gmii receive front end
`timescale 1ns/1ns
`default_nettype none

module gmii_rx_top import gmii_rx_pkg::*; (
    input  wire logic          clk_io,
    input  wire logic          reset,
    input  wire gmii_byte_t    rxd,
    input  wire logic          rx_dv,
    input  wire logic          rx_er,
    output wire logic          out_valid,
    output wire rx_byte_t      out_byte,
    output wire logic          status_valid,
    output wire frame_status_t status,
    output wire logic          false_carrier
);

    // forwarded receive clock for everything behind the capture
    wire logic      rx_clk;
    wire gmii_sym_t sym;

    // pin capture and pair decode
    gmii_rx_phy_if phy_if_i (
        .clk_io        (clk_io),
        .reset         (reset),
        .rxd           (rxd),
        .rx_dv         (rx_dv),
        .rx_er         (rx_er),
        .rx_clk        (rx_clk),
        .sym           (sym),
        .false_carrier (false_carrier)
    );

    // preamble/sfd strip, one byte of lookahead
    gmii_rx_framer framer_i (
        .clk_io    (rx_clk),
        .reset     (reset),
        .sym       (sym),
        .out_valid (out_valid),
        .out_byte  (out_byte)
    );

    // fcs check sits beside the byte stream
    gmii_rx_crc_check crc_check_i (
        .clk_io       (rx_clk),
        .reset        (reset),
        .out_valid    (out_valid),
        .out_byte     (out_byte),
        .status_valid (status_valid),
        .status       (status)
    );

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
gmii_rx_pkg.sv
gmii_rx_phy_if.sv
gmii_rx_framer.sv
gmii_rx_crc_check.sv
gmii_rx_top.sv
tb_gmii_rx.sv

// File: tb_gmii_rx.sv
// gmii receive testbench
`timescale 1ns/1ns
`default_nettype none

`include "gmii_rx_defs.svh"

module tb_gmii_rx import gmii_rx_pkg::*; ();

    localparam int NROWS = 11;
    localparam int STATUS_TIMEOUT = 200;
    localparam int DROP_SPAN = 16;
    localparam logic [7:0] NO_ERR = 8'hFF;

    // one frame per row
    typedef struct packed {
        logic [7:0] pre_len;
        logic [7:0] pay_len;
        logic       bad_fcs;
        logic [7:0] err_idx;
        logic       fc_before;
        gmii_byte_t sfd;
        logic [7:0] gap;
    } row_t;

    logic          clk_io;
    logic          reset;
    gmii_byte_t    rxd;
    logic          rx_dv;
    logic          rx_er;
    logic          out_valid;
    rx_byte_t      out_byte;
    logic          status_valid;
    frame_status_t status;
    logic          false_carrier;

    row_t          rows [NROWS];
    rx_byte_t      exp_bytes[$];
    rx_byte_t      got_bytes[$];
    frame_status_t exp_status[$];
    frame_status_t got_status[$];
    int            fc_seen = 0;
    int            fc_expected = 0;
    int            value_errors = 0;
    int            timeout_errors = 0;
    int            seed_dummy;
    int            row_idx;

    gmii_rx_top dut_i (
        .clk_io        (clk_io),
        .reset         (reset),
        .rxd           (rxd),
        .rx_dv         (rx_dv),
        .rx_er         (rx_er),
        .out_valid     (out_valid),
        .out_byte      (out_byte),
        .status_valid  (status_valid),
        .status        (status),
        .false_carrier (false_carrier)
    );

    initial begin
        clk_io = 1'b0;
        forever #4 clk_io = ~clk_io;
    end

    // outputs sampled mid-cycle, well away from the active edge
    always @(negedge clk_io) begin
        if (!reset) begin
            if (out_valid) begin
                got_bytes.push_back(out_byte);
            end
            if (status_valid) begin
                got_status.push_back(status);
            end
            if (false_carrier) begin
                fc_seen++;
            end
        end
    end

    // bit-at-a-time reflected crc-32
    function automatic crc32_t ref_crc_bits(input crc32_t crc_in, input gmii_byte_t data);
        crc32_t c;
        logic   fb;
        int     b;
        c = crc_in;
        for (b = 0; b < 8; b++) begin
            fb = c[0] ^ data[b];
            c = c >> 1;
            if (fb) begin
                c = c ^ `CRC32_POLY;
            end
        end
        return c;
    endfunction

    function automatic row_t make_row(input int pre, input int pay, input logic bad,
                                      input logic [7:0] err, input logic fc,
                                      input gmii_byte_t sfd, input int gap);
        row_t r;
        r.pre_len   = pre[7:0];
        r.pay_len   = pay[7:0];
        r.bad_fcs   = bad;
        r.err_idx   = err;
        r.fc_before = fc;
        r.sfd       = sfd;
        r.gap       = gap[7:0];
        return r;
    endfunction

    task automatic fill_table();
        // preamble, payload, bad fcs, error index, false carrier, sfd, gap
        rows[0]  = make_row(7, 16, 1'b0, NO_ERR, 1'b0, 8'hD5, 12);
        rows[1]  = make_row(7, 20, 1'b1, NO_ERR, 1'b0, 8'hD5, 12);
        rows[2]  = make_row(7, 24, 1'b0, 8'd5, 1'b0, 8'hD5, 12);
        // short preamble, then a clean frame
        rows[3]  = make_row(1, 10, 1'b0, NO_ERR, 1'b0, 8'hD5, 4);
        rows[4]  = make_row(7, 12, 1'b0, NO_ERR, 1'b0, 8'hD5, 12);
        // wrong delimiter byte
        rows[5]  = make_row(7, 10, 1'b0, NO_ERR, 1'b0, 8'h5D, 4);
        rows[6]  = make_row(7, 8, 1'b0, NO_ERR, 1'b1, 8'hD5, 12);
        rows[7]  = make_row(2, 46, 1'b0, NO_ERR, 1'b0, 8'hD5, 12);
        // three frames with one idle cycle between them
        rows[8]  = make_row(7, 30, 1'b0, NO_ERR, 1'b0, 8'hD5, 1);
        rows[9]  = make_row(7, 15, 1'b1, NO_ERR, 1'b0, 8'hD5, 1);
        rows[10] = make_row(7, 9, 1'b0, NO_ERR, 1'b0, 8'hD5, 12);
    endtask

    // pins change 1 ns after the rising edge
    task automatic drive_sym(input gmii_byte_t d, input logic dv, input logic er);
        @(posedge clk_io);
        #1;
        rxd   = d;
        rx_dv = dv;
        rx_er = er;
    endtask

    task automatic wait_status(input int idx);
        int n;
        n = 0;
        while ((got_status.size() < exp_status.size()) && (n < STATUS_TIMEOUT)) begin
            @(posedge clk_io);
            n++;
        end
        if (got_status.size() < exp_status.size()) begin
            $display("timeout: row %0d never delivered its frame status", idx);
            timeout_errors++;
        end
    endtask

    task automatic check_queues(input int idx);
        int i;
        if (got_bytes.size() != exp_bytes.size()) begin
            $display("ERR %0t: row %0d gave %0d bytes, expected %0d", $time, idx,
                     got_bytes.size(), exp_bytes.size());
            value_errors++;
        end
        for (i = 0; (i < got_bytes.size()) && (i < exp_bytes.size()); i++) begin
            if (got_bytes[i] !== exp_bytes[i]) begin
                $display("ERR %0t: row %0d byte %0d got %h/%b/%b, expected %h/%b/%b",
                         $time, idx, i, got_bytes[i].data, got_bytes[i].last,
                         got_bytes[i].err, exp_bytes[i].data, exp_bytes[i].last,
                         exp_bytes[i].err);
                value_errors++;
            end
        end
        if (got_status.size() != exp_status.size()) begin
            $display("ERR %0t: row %0d gave %0d status pulses, expected %0d", $time, idx,
                     got_status.size(), exp_status.size());
            value_errors++;
        end
        for (i = 0; (i < got_status.size()) && (i < exp_status.size()); i++) begin
            if (got_status[i] !== exp_status[i]) begin
                $display("ERR %0t: row %0d status %0d got %b, expected %b", $time, idx, i,
                         got_status[i], exp_status[i]);
                value_errors++;
            end
        end
        if (fc_seen != fc_expected) begin
            $display("ERR %0t: row %0d false_carrier pulses %0d, expected %0d", $time, idx,
                     fc_seen, fc_expected);
            value_errors++;
            fc_expected = fc_seen;
        end
        got_bytes.delete();
        exp_bytes.delete();
        got_status.delete();
        exp_status.delete();
    endtask

    task automatic run_row(input int idx, input row_t r);
        gmii_byte_t    frame_q[$];
        logic          er_q[$];
        gmii_byte_t    pay;
        crc32_t        crc;
        crc32_t        fcs;
        logic          dropped;
        logic          err_seen;
        rx_byte_t      eb;
        frame_status_t es;
        int            i;
        // too few preamble bytes or a wrong delimiter loses the frame
        dropped  = (r.pre_len < `GMII_MIN_PREAMBLE) || (r.sfd != `GMII_SFD);
        err_seen = 1'b0;
        crc      = '1;
        if (r.fc_before) begin
            // false carrier lasting two cycles counts once
            drive_sym(8'h0E, 1'b0, 1'b1);
            drive_sym(8'h0E, 1'b0, 1'b1);
            drive_sym(8'h00, 1'b0, 1'b0);
            drive_sym(8'h00, 1'b0, 1'b0);
            fc_expected++;
        end
        for (i = 0; i < r.pre_len; i++) begin
            frame_q.push_back(`GMII_PREAMBLE);
            er_q.push_back(1'b0);
        end
        frame_q.push_back(r.sfd);
        er_q.push_back(1'b0);
        for (i = 0; i < r.pay_len; i++) begin
            pay = gmii_byte_t'($urandom);
            crc = ref_crc_bits(crc, pay);
            frame_q.push_back(pay);
            er_q.push_back(i == r.err_idx);
            // err sticks from the error byte to the end
            err_seen = err_seen | (i == r.err_idx);
            eb.data  = pay;
            eb.last  = 1'b0;
            eb.err   = err_seen;
            if (!dropped) begin
                exp_bytes.push_back(eb);
            end
        end
        // fcs goes out inverted, low byte first
        fcs = ~crc;
        if (r.bad_fcs) begin
            fcs[3] = ~fcs[3];
        end
        for (i = 0; i < 4; i++) begin
            eb.data = fcs[8*i +: 8];
            eb.last = (i == 3);
            eb.err  = err_seen;
            frame_q.push_back(fcs[8*i +: 8]);
            er_q.push_back(1'b0);
            if (!dropped) begin
                exp_bytes.push_back(eb);
            end
        end
        es.bad_crc = r.bad_fcs;
        es.phy_err = err_seen;
        es.good    = !r.bad_fcs && !err_seen;
        if (!dropped) begin
            exp_status.push_back(es);
        end
        for (i = 0; i < frame_q.size(); i++) begin
            drive_sym(frame_q[i], 1'b1, er_q[i]);
        end
        for (i = 0; i < r.gap; i++) begin
            drive_sym(8'h00, 1'b0, 1'b0);
        end
        if (dropped) begin
            for (i = 0; i < DROP_SPAN; i++) begin
                drive_sym(8'h00, 1'b0, 1'b0);
            end
            check_queues(idx);
        end else if (r.gap > 1) begin
            // a one-cycle gap leaves the check to the next spaced row
            wait_status(idx);
            check_queues(idx);
        end
    endtask

    initial begin
        seed_dummy = $urandom(62);
        reset = 1'b1;
        rxd   = 8'h00;
        rx_dv = 1'b0;
        rx_er = 1'b0;
        fill_table();
        repeat (16) @(posedge clk_io);
        #1;
        reset = 1'b0;
        for (row_idx = 0; row_idx < NROWS; row_idx++) begin
            run_row(row_idx, rows[row_idx]);
        end
        $display("value errors: %0d, timeouts: %0d", value_errors, timeout_errors);
        if ((value_errors == 0) && (timeout_errors == 0)) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
